// ==== lbfgs_pkg.sv ====
package lbfgs_pkg;

    ////////////////////////////////////////
    // sizes and fixed-point constants
    ////////////////////////////////////////
    localparam int num_elements = 4;
    localparam int frac_bits = 16;
    localparam int max_iter = 32;
    localparam int iter_w = 6;

    // signed Q16.16
    typedef logic signed [31:0] fix_t;

    localparam fix_t fix_one = fix_t'(1 << frac_bits);
    // 2^-10 on the change of f
    localparam fix_t eps_f = fix_t'(1 << (frac_bits - 10));
    // 2^-8 on each gradient component
    localparam fix_t eps_g = fix_t'(1 << (frac_bits - 8));
    localparam fix_t alpha_min = fix_t'(1 << (frac_bits - 12));

    ////////////////////////////////////////
    // shared types
    ////////////////////////////////////////
    typedef fix_t [num_elements-1:0] vec_t;
    typedef logic [1:0] elem_idx_t;
    typedef logic [iter_w-1:0] iter_t;

    typedef struct packed {
        fix_t weight;
        fix_t mean;
    } cfg_t;

    typedef struct packed {
        vec_t  x;
        fix_t  f;
        iter_t iter;
        logic  converged;
    } result_t;

    typedef enum logic {op_axpy, op_dot} vec_op_t;

    typedef enum logic [2:0] {
        st_idle, st_grad0, st_search, st_judge, st_next, st_done
    } ctrl_state_t;

    // full product and an arithmetic shift back to Q16.16
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        logic signed [63:0] prod;
        prod = longint'(a) * longint'(b);
        return fix_t'(prod >>> frac_bits);
    endfunction

endpackage

// ==== objective_unit.sv ====
module objective_unit (
    input  logic                  clk,
    input  logic                  rst_LBFGS,
    input  logic                  cfg_we,
    input  lbfgs_pkg::elem_idx_t  cfg_addr,
    input  lbfgs_pkg::cfg_t       cfg_data,
    input  lbfgs_pkg::vec_t       x,
    input  logic                  f_start,
    input  logic                  g_start,
    output logic                  f_done,
    output lbfgs_pkg::fix_t       f_val,
    output logic                  grad_valid,
    output logic                  grad_last,
    output lbfgs_pkg::fix_t       grad_val
);

    lbfgs_pkg::cfg_t      cfg_mem [lbfgs_pkg::num_elements];
    lbfgs_pkg::vec_t      x_q;
    lbfgs_pkg::elem_idx_t idx;
    logic                 f_busy;
    logic                 g_busy;
    logic                 last_elem;
    lbfgs_pkg::fix_t      diff;
    lbfgs_pkg::fix_t      term;

    ////////////////////////////////////////
    // per-element datapath
    ////////////////////////////////////////
    assign diff      = x_q[idx] - cfg_mem[idx].mean;
    // square truncated before the weight is applied
    assign term      = lbfgs_pkg::fix_mul(cfg_mem[idx].weight, lbfgs_pkg::fix_mul(diff, diff));
    assign last_elem = (idx == lbfgs_pkg::elem_idx_t'(lbfgs_pkg::num_elements - 1));

    // gradient stream of one element per cycle
    assign grad_valid = g_busy;
    assign grad_last  = g_busy && last_elem;
    assign grad_val   = lbfgs_pkg::fix_mul(cfg_mem[idx].weight, diff + diff);

    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            f_busy <= 1'b0;
            g_busy <= 1'b0;
            f_done <= 1'b0;
            idx    <= '0;
            for (int i = 0; i < lbfgs_pkg::num_elements; i++) begin
                cfg_mem[i] <= '0;
            end
        end else begin
            f_done <= 1'b0;
            if (cfg_we) begin
                cfg_mem[cfg_addr] <= cfg_data;
            end
            if (f_start || g_start) begin
                x_q    <= x;
                idx    <= '0;
                f_busy <= f_start;
                g_busy <= g_start;
                if (f_start) begin
                    f_val <= '0;
                end
            end else if (f_busy || g_busy) begin
                idx <= idx + lbfgs_pkg::elem_idx_t'(1);
                // f_val is left alone in gradient mode
                if (f_busy) begin
                    f_val <= f_val + term;
                end
                if (last_elem) begin
                    f_busy <= 1'b0;
                    g_busy <= 1'b0;
                    f_done <= f_busy;
                end
            end
        end
    end

endmodule

// ==== vector_unit.sv ====
module vector_unit (
    input  logic                clk,
    input  logic                rst_LBFGS,
    input  logic                start,
    input  lbfgs_pkg::vec_op_t  op,
    input  lbfgs_pkg::vec_t     a,
    input  lbfgs_pkg::vec_t     b,
    input  lbfgs_pkg::fix_t     scale,
    output logic                done,
    output lbfgs_pkg::vec_t     vec_out,
    output lbfgs_pkg::fix_t     dot_out
);

    lbfgs_pkg::vec_op_t   op_q;
    lbfgs_pkg::vec_t      a_q;
    lbfgs_pkg::vec_t      b_q;
    lbfgs_pkg::fix_t      scale_q;
    lbfgs_pkg::elem_idx_t idx;
    logic                 busy;
    logic                 last_lane;
    lbfgs_pkg::fix_t      prod;

    assign last_lane = (idx == lbfgs_pkg::elem_idx_t'(lbfgs_pkg::num_elements - 1));

    // one shared multiplier for both ops
    assign prod = lbfgs_pkg::fix_mul((op_q == lbfgs_pkg::op_axpy) ? scale_q : a_q[idx],
                                     b_q[idx]);

    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            busy <= 1'b0;
            done <= 1'b0;
            idx  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                op_q    <= op;
                a_q     <= a;
                b_q     <= b;
                scale_q <= scale;
                idx     <= '0;
                busy    <= 1'b1;
                if (op == lbfgs_pkg::op_dot) begin
                    dot_out <= '0;
                end
            end else if (busy) begin
                idx <= idx + lbfgs_pkg::elem_idx_t'(1);
                if (op_q == lbfgs_pkg::op_axpy) begin
                    vec_out[idx] <= a_q[idx] + prod;
                end else begin
                    dot_out <= dot_out + prod;
                end
                if (last_lane) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== line_search.sv ====
module line_search (
    input  logic             clk,
    input  logic             rst_LBFGS,
    input  logic             start,
    input  lbfgs_pkg::fix_t  phi0,
    input  lbfgs_pkg::fix_t  slope,
    input  logic             f_done,
    input  lbfgs_pkg::fix_t  f_val,
    input  logic             axpy_done,
    output logic             f_req,
    output logic             axpy_req,
    output lbfgs_pkg::fix_t  alpha,
    output logic             done,
    output logic             stall
);

    typedef enum logic [1:0] {ls_idle, ls_axpy, ls_eval} ls_state_t;

    ls_state_t       state;
    lbfgs_pkg::fix_t phi0_q;
    lbfgs_pkg::fix_t slope_q;
    lbfgs_pkg::fix_t alpha_half;
    lbfgs_pkg::fix_t bound;
    logic            accept;

    assign alpha_half = alpha >>> 1;
    // sufficient decrease, c = 1/4
    assign bound  = phi0_q + (lbfgs_pkg::fix_mul(alpha, slope_q) >>> 2);
    assign accept = (f_val <= bound);

    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            state    <= ls_idle;
            f_req    <= 1'b0;
            axpy_req <= 1'b0;
            done     <= 1'b0;
        end else begin
            f_req    <= 1'b0;
            axpy_req <= 1'b0;
            done     <= 1'b0;
            case (state)
                ls_idle: begin
                    if (start) begin
                        phi0_q   <= phi0;
                        slope_q  <= slope;
                        alpha    <= lbfgs_pkg::fix_one;
                        axpy_req <= 1'b1;
                        state    <= ls_axpy;
                    end
                end
                ls_axpy: begin
                    // trial point ready, now phi(alpha)
                    if (axpy_done) begin
                        f_req <= 1'b1;
                        state <= ls_eval;
                    end
                end
                ls_eval: begin
                    if (f_done) begin
                        if (accept) begin
                            done  <= 1'b1;
                            stall <= 1'b0;
                            state <= ls_idle;
                        end else if (alpha_half < lbfgs_pkg::alpha_min) begin
                            done  <= 1'b1;
                            stall <= 1'b1;
                            state <= ls_idle;
                        end else begin
                            alpha    <= alpha_half;
                            axpy_req <= 1'b1;
                            state    <= ls_axpy;
                        end
                    end
                end
                default: begin
                    state <= ls_idle;
                end
            endcase
        end
    end

endmodule

// ==== lbfgs_ctrl.sv ====
module lbfgs_ctrl (
    input  logic                clk,
    input  logic                rst_LBFGS,
    input  logic                in_valid,
    output logic                in_ready,
    input  lbfgs_pkg::vec_t     in_x,
    output logic                res_valid,
    input  logic                res_ready,
    output lbfgs_pkg::result_t  res,
    output lbfgs_pkg::vec_t     obj_x,
    output logic                f_start,
    output logic                g_start,
    input  logic                f_done,
    input  lbfgs_pkg::fix_t     f_val,
    input  logic                grad_valid,
    input  logic                grad_last,
    input  lbfgs_pkg::fix_t     grad_val,
    output logic                vu_start,
    output lbfgs_pkg::vec_op_t  vu_op,
    output lbfgs_pkg::vec_t     vu_a,
    output lbfgs_pkg::vec_t     vu_b,
    output lbfgs_pkg::fix_t     vu_scale,
    input  logic                vu_done,
    input  lbfgs_pkg::vec_t     vu_vec,
    input  lbfgs_pkg::fix_t     vu_dot,
    output logic                ls_start,
    output lbfgs_pkg::fix_t     ls_phi0,
    output lbfgs_pkg::fix_t     ls_slope,
    input  logic                ls_f_req,
    input  logic                ls_axpy_req,
    input  lbfgs_pkg::fix_t     ls_alpha,
    input  logic                ls_done,
    input  logic                ls_stall
);

    lbfgs_pkg::ctrl_state_t state;
    // search: 0 while g.d runs, 1 while the line search owns the units
    logic                   phase;
    logic                   own_f_start;
    logic                   own_vu_start;
    logic                   ls_owns;
    lbfgs_pkg::iter_t       iter;
    lbfgs_pkg::vec_t        x;
    lbfgs_pkg::vec_t        x_new;
    lbfgs_pkg::vec_t        g;
    lbfgs_pkg::vec_t        d;
    lbfgs_pkg::vec_t        grad_next;
    lbfgs_pkg::fix_t        f_cur;
    lbfgs_pkg::fix_t        f_new;
    lbfgs_pkg::fix_t        f_diff;
    logic                   f_small;
    logic                   grad_small;

    // steepest descent direction
    function automatic lbfgs_pkg::vec_t neg_vec(input lbfgs_pkg::vec_t v);
        lbfgs_pkg::vec_t r;
        for (int i = 0; i < lbfgs_pkg::num_elements; i++) begin
            r[i] = -v[i];
        end
        return r;
    endfunction

    assign in_ready  = (state == lbfgs_pkg::st_idle);
    assign res_valid = (state == lbfgs_pkg::st_done);

    ////////////////////////////////////////
    // unit sharing with the line search
    ////////////////////////////////////////
    assign ls_owns  = (state == lbfgs_pkg::st_search) && phase;
    assign f_start  = ls_owns ? ls_f_req : own_f_start;
    assign vu_start = ls_owns ? ls_axpy_req : own_vu_start;
    assign vu_op    = ls_owns ? lbfgs_pkg::op_axpy : lbfgs_pkg::op_dot;
    assign vu_a     = ls_owns ? x : g;
    assign vu_b     = d;
    assign vu_scale = ls_alpha;
    assign ls_phi0  = f_cur;
    // g.d, held by the vector unit until its next start
    assign ls_slope = vu_dot;

    // trial point while searching, accepted point while judging
    always_comb begin
        if (state == lbfgs_pkg::st_search) begin
            obj_x = vu_vec;
        end else if (state == lbfgs_pkg::st_judge) begin
            obj_x = x_new;
        end else begin
            obj_x = x;
        end
    end

    ////////////////////////////////////////
    // convergence tests
    ////////////////////////////////////////
    // element 0 arrives first and ends up in lane 0
    assign grad_next = {grad_val, g[lbfgs_pkg::num_elements-1:1]};
    assign f_diff    = f_new - f_cur;
    assign f_small   = (f_diff <= lbfgs_pkg::eps_f) && (f_diff >= -lbfgs_pkg::eps_f);

    always_comb begin
        lbfgs_pkg::fix_t gi;
        grad_small = 1'b1;
        for (int i = 0; i < lbfgs_pkg::num_elements; i++) begin
            gi = grad_next[i];
            if (gi > lbfgs_pkg::eps_g || gi < -lbfgs_pkg::eps_g) begin
                grad_small = 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // outer iteration
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            state        <= lbfgs_pkg::st_idle;
            phase        <= 1'b0;
            own_f_start  <= 1'b0;
            own_vu_start <= 1'b0;
            g_start      <= 1'b0;
            ls_start     <= 1'b0;
        end else begin
            own_f_start  <= 1'b0;
            own_vu_start <= 1'b0;
            g_start      <= 1'b0;
            ls_start     <= 1'b0;
            if (grad_valid) begin
                g <= grad_next;
            end
            case (state)
                lbfgs_pkg::st_idle: begin
                    if (in_valid) begin
                        x           <= in_x;
                        iter        <= lbfgs_pkg::iter_t'(1);
                        own_f_start <= 1'b1;
                        state       <= lbfgs_pkg::st_grad0;
                    end
                end
                lbfgs_pkg::st_grad0: begin
                    if (f_done) begin
                        f_cur   <= f_val;
                        g_start <= 1'b1;
                    end
                    if (grad_last) begin
                        d            <= neg_vec(grad_next);
                        phase        <= 1'b0;
                        own_vu_start <= 1'b1;
                        state        <= lbfgs_pkg::st_search;
                    end
                end
                lbfgs_pkg::st_search: begin
                    if (!phase && vu_done) begin
                        ls_start <= 1'b1;
                        phase    <= 1'b1;
                    end
                    if (phase && ls_done) begin
                        if (ls_stall) begin
                            res   <= '{x: x, f: f_cur, iter: iter, converged: 1'b0};
                            state <= lbfgs_pkg::st_done;
                        end else begin
                            x_new   <= vu_vec;
                            f_new   <= f_val;
                            g_start <= 1'b1;
                            state   <= lbfgs_pkg::st_judge;
                        end
                    end
                end
                lbfgs_pkg::st_judge: begin
                    if (grad_last) begin
                        if (f_small || grad_small) begin
                            res   <= '{x: x_new, f: f_new, iter: iter, converged: 1'b1};
                            state <= lbfgs_pkg::st_done;
                        end else if (iter == lbfgs_pkg::iter_t'(lbfgs_pkg::max_iter)) begin
                            res   <= '{x: x_new, f: f_new, iter: iter, converged: 1'b0};
                            state <= lbfgs_pkg::st_done;
                        end else begin
                            state <= lbfgs_pkg::st_next;
                        end
                    end
                end
                lbfgs_pkg::st_next: begin
                    // g already holds the gradient at x_new
                    x            <= x_new;
                    f_cur        <= f_new;
                    iter         <= iter + lbfgs_pkg::iter_t'(1);
                    d            <= neg_vec(g);
                    phase        <= 1'b0;
                    own_vu_start <= 1'b1;
                    state        <= lbfgs_pkg::st_search;
                end
                lbfgs_pkg::st_done: begin
                    if (res_ready) begin
                        state <= lbfgs_pkg::st_idle;
                    end
                end
                default: begin
                    state <= lbfgs_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

// ==== lbfgs_top.sv ====
module lbfgs_top (
    input  logic                  clk,
    input  logic                  rst_LBFGS,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  lbfgs_pkg::vec_t       in_x,
    input  logic                  cfg_we,
    input  lbfgs_pkg::elem_idx_t  cfg_addr,
    input  lbfgs_pkg::cfg_t       cfg_data,
    output logic                  res_valid,
    input  logic                  res_ready,
    output lbfgs_pkg::result_t    res
);

    // objective unit
    lbfgs_pkg::vec_t    obj_x;
    logic               f_start;
    logic               g_start;
    logic               f_done;
    lbfgs_pkg::fix_t    f_val;
    logic               grad_valid;
    logic               grad_last;
    lbfgs_pkg::fix_t    grad_val;

    // vector unit
    logic               vu_start;
    lbfgs_pkg::vec_op_t vu_op;
    lbfgs_pkg::vec_t    vu_a;
    lbfgs_pkg::vec_t    vu_b;
    lbfgs_pkg::fix_t    vu_scale;
    logic               vu_done;
    lbfgs_pkg::vec_t    vu_vec;
    lbfgs_pkg::fix_t    vu_dot;

    // line search
    logic               ls_start;
    lbfgs_pkg::fix_t    ls_phi0;
    lbfgs_pkg::fix_t    ls_slope;
    logic               ls_f_req;
    logic               ls_axpy_req;
    lbfgs_pkg::fix_t    ls_alpha;
    logic               ls_done;
    logic               ls_stall;

    lbfgs_ctrl ctrl_i (
        .clk         (clk),
        .rst_LBFGS   (rst_LBFGS),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_x        (in_x),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res         (res),
        .obj_x       (obj_x),
        .f_start     (f_start),
        .g_start     (g_start),
        .f_done      (f_done),
        .f_val       (f_val),
        .grad_valid  (grad_valid),
        .grad_last   (grad_last),
        .grad_val    (grad_val),
        .vu_start    (vu_start),
        .vu_op       (vu_op),
        .vu_a        (vu_a),
        .vu_b        (vu_b),
        .vu_scale    (vu_scale),
        .vu_done     (vu_done),
        .vu_vec      (vu_vec),
        .vu_dot      (vu_dot),
        .ls_start    (ls_start),
        .ls_phi0     (ls_phi0),
        .ls_slope    (ls_slope),
        .ls_f_req    (ls_f_req),
        .ls_axpy_req (ls_axpy_req),
        .ls_alpha    (ls_alpha),
        .ls_done     (ls_done),
        .ls_stall    (ls_stall)
    );

    objective_unit obj_i (
        .clk        (clk),
        .rst_LBFGS  (rst_LBFGS),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .x          (obj_x),
        .f_start    (f_start),
        .g_start    (g_start),
        .f_done     (f_done),
        .f_val      (f_val),
        .grad_valid (grad_valid),
        .grad_last  (grad_last),
        .grad_val   (grad_val)
    );

    vector_unit vu_i (
        .clk       (clk),
        .rst_LBFGS (rst_LBFGS),
        .start     (vu_start),
        .op        (vu_op),
        .a         (vu_a),
        .b         (vu_b),
        .scale     (vu_scale),
        .done      (vu_done),
        .vec_out   (vu_vec),
        .dot_out   (vu_dot)
    );

    // the search sees every unit done pulse, but only reacts while running
    line_search ls_i (
        .clk       (clk),
        .rst_LBFGS (rst_LBFGS),
        .start     (ls_start),
        .phi0      (ls_phi0),
        .slope     (ls_slope),
        .f_done    (f_done),
        .f_val     (f_val),
        .axpy_done (vu_done),
        .f_req     (ls_f_req),
        .axpy_req  (ls_axpy_req),
        .alpha     (ls_alpha),
        .done      (ls_done),
        .stall     (ls_stall)
    );

endmodule

// ==== tb_clock.sv ====
module tb_clock (
    output logic clk
);

    // 10 time unit period
    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

endmodule

// ==== tb_lbfgs.sv ====
module tb_lbfgs;

    localparam int num_runs = 22;
    localparam int search_steps = $clog2(lbfgs_pkg::fix_one / lbfgs_pkg::alpha_min);
    localparam int cycle_limit = num_runs * lbfgs_pkg::max_iter * (2 + 2 * search_steps)
                                 * (lbfgs_pkg::num_elements + 3) * 4;
    // coordinates in [-8.0, 8.0], weights in [0, 2.0]
    localparam int unsigned coord_span = 32'd1048577;
    localparam int coord_low = -524288;
    localparam int unsigned weight_span = 32'd131073;

    logic                 clk;
    logic                 rst_LBFGS;
    logic                 in_valid;
    logic                 in_ready;
    lbfgs_pkg::vec_t      in_x;
    logic                 cfg_we;
    lbfgs_pkg::elem_idx_t cfg_addr;
    lbfgs_pkg::cfg_t      cfg_data;
    logic                 res_valid;
    logic                 res_ready;
    lbfgs_pkg::result_t   res;

    logic [31:0]          rng;
    lbfgs_pkg::vec_t      w_vec;
    lbfgs_pkg::vec_t      m_vec;
    lbfgs_pkg::vec_t      x0_q;
    lbfgs_pkg::fix_t      f_x0;
    logic                 exact_run;
    logic                 job_open;
    int                   results_seen;
    int                   cycles = 0;
    lbfgs_pkg::fix_t      ref_f;
    lbfgs_pkg::fix_t      f_step;
    logic                 grad_ok;
    logic                 f_step_ok;

    tb_clock clk_i (
        .clk (clk)
    );

    lbfgs_top dut_i (
        .clk       (clk),
        .rst_LBFGS (rst_LBFGS),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_x      (in_x),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    ////////////////////////////////////////
    // reference model, Q16.16
    ////////////////////////////////////////
    function automatic lbfgs_pkg::fix_t q_mul(input lbfgs_pkg::fix_t a, input lbfgs_pkg::fix_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return lbfgs_pkg::fix_t'(p >>> lbfgs_pkg::frac_bits);
    endfunction

    function automatic lbfgs_pkg::fix_t model_f(input lbfgs_pkg::vec_t v,
                                                input lbfgs_pkg::vec_t w,
                                                input lbfgs_pkg::vec_t m);
        lbfgs_pkg::fix_t acc;
        lbfgs_pkg::fix_t dlt;
        acc = '0;
        for (int i = 0; i < lbfgs_pkg::num_elements; i++) begin
            dlt = v[i] - m[i];
            acc = acc + q_mul(w[i], q_mul(dlt, dlt));
        end
        return acc;
    endfunction

    // every component of 2w(x - m) inside eps_g
    function automatic logic grad_within_eps(input lbfgs_pkg::vec_t v,
                                             input lbfgs_pkg::vec_t w,
                                             input lbfgs_pkg::vec_t m);
        lbfgs_pkg::fix_t gi;
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < lbfgs_pkg::num_elements; i++) begin
            gi = q_mul(w[i] + w[i], v[i] - m[i]);
            if (gi > lbfgs_pkg::eps_g || gi < -lbfgs_pkg::eps_g) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    always_comb begin
        ref_f   = model_f(res.x, w_vec, m_vec);
        grad_ok = grad_within_eps(res.x, w_vec, m_vec);
        f_step  = res.f - f_x0;
    end
    assign f_step_ok = (f_step <= lbfgs_pkg::eps_f) && (f_step >= -lbfgs_pkg::eps_f);

    ////////////////////////////////////////
    // failure reporting and run limit
    ////////////////////////////////////////
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_value(input string msg);
        stop_run($sformatf("error at time %0t: %s", $time, msg));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            stop_run($sformatf("timeout: no final result after %0d cycles", cycle_limit));
        end
    end

    // a job is open from the accepted input to the taken result
    always_ff @(posedge clk) begin
        if (!rst_LBFGS) begin
            job_open     <= 1'b0;
            results_seen <= 0;
        end else if (in_valid && in_ready) begin
            job_open <= 1'b1;
        end else if (res_valid && res_ready) begin
            job_open     <= 1'b0;
            results_seen <= results_seen + 1;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    reset_check: assert property (@(posedge clk) !rst_LBFGS |=> in_ready && !res_valid)
        else report_value("after reset in_ready must be high and res_valid low");

    busy_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        job_open |-> !in_ready)
        else report_value("in_ready high while a problem is still open");

    hold_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        res_valid && !res_ready |=> res_valid && $stable(res))
        else report_value("result dropped or changed under back-pressure");

    f_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        res_valid && res_ready |-> res.f == ref_f)
        else report_value("res.f differs from the model objective at res.x");

    decrease_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        res_valid && res_ready |-> res.f <= f_x0)
        else report_value("res.f is greater than the objective at x0");

    iter_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        res_valid && res_ready |-> res.iter >= lbfgs_pkg::iter_t'(1)
                                   && res.iter <= lbfgs_pkg::iter_t'(lbfgs_pkg::max_iter))
        else report_value("iteration count out of range");

    stop_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        res_valid && res_ready && !res.converged |->
            res.iter == lbfgs_pkg::iter_t'(lbfgs_pkg::max_iter) || res.x == x0_q)
        else report_value("not converged without hitting the cap or stalling at x0");

    // with one iteration the previous f is the one at x0
    reason_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        res_valid && res_ready && res.converged && res.iter == lbfgs_pkg::iter_t'(1) |->
            grad_ok || f_step_ok)
        else report_value("converged although neither the gradient nor the f test holds");

    exact_check: assert property (@(posedge clk) disable iff (!rst_LBFGS)
        res_valid && res_ready && exact_run |->
            res.x == x0_q && res.f == 32'sd0 && res.converged
            && res.iter == lbfgs_pkg::iter_t'(1))
        else report_value("start at the minimum did not return x0 with f = 0 in one iteration");

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////
    task automatic draw(input int unsigned span, input int low, output lbfgs_pkg::fix_t v);
        rng = xorshift(rng);
        v = lbfgs_pkg::fix_t'(int'(rng % span) + low);
    endtask

    task automatic wait_ready();
        while (!in_ready) begin
            @(posedge clk);
        end
    endtask

    // zero_w clears every weight and keeps the current means
    task automatic load_config(input logic zero_w);
        lbfgs_pkg::fix_t w;
        lbfgs_pkg::fix_t m;
        wait_ready();
        for (int i = 0; i < lbfgs_pkg::num_elements; i++) begin
            if (zero_w) begin
                w = '0;
                m = m_vec[i];
            end else begin
                draw(weight_span, 0, w);
                draw(coord_span, coord_low, m);
            end
            w_vec[i] = w;
            m_vec[i] = m;
            cfg_we   <= 1'b1;
            cfg_addr <= lbfgs_pkg::elem_idx_t'(i);
            cfg_data <= '{weight: w, mean: m};
            @(posedge clk);
        end
        cfg_we <= 1'b0;
    endtask

    task automatic draw_vec(output lbfgs_pkg::vec_t v);
        for (int i = 0; i < lbfgs_pkg::num_elements; i++) begin
            draw(coord_span, coord_low, v[i]);
        end
    endtask

    task automatic run_problem(input lbfgs_pkg::vec_t x0, input logic exact);
        int unsigned hold;
        wait_ready();
        x0_q      = x0;
        exact_run = exact;
        f_x0      = model_f(x0, w_vec, m_vec);
        in_valid <= 1'b1;
        in_x     <= x0;
        @(posedge clk);
        wait_ready();
        in_valid <= 1'b0;
        while (!res_valid) begin
            @(posedge clk);
        end
        // back-pressure of 0 to 15 cycles
        rng = xorshift(rng);
        hold = rng % 32'd16;
        repeat (hold) @(posedge clk);
        res_ready <= 1'b1;
        @(posedge clk);
        res_ready <= 1'b0;
    endtask

    initial begin
        lbfgs_pkg::vec_t x0;
        rng       = 32'd1;
        w_vec     = '0;
        m_vec     = '0;
        x0_q      = '0;
        f_x0      = '0;
        exact_run = 1'b0;
        rst_LBFGS = 1'b0;
        in_valid  = 1'b0;
        in_x      = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        res_ready = 1'b0;
        repeat (10) @(posedge clk);
        rst_LBFGS <= 1'b1;
        @(posedge clk);

        // start exactly at the minimum
        load_config(1'b0);
        run_problem(m_vec, 1'b1);

        for (int r = 0; r < 20; r++) begin
            load_config(1'b0);
            draw_vec(x0);
            run_problem(x0, 1'b0);
        end

        // flat objective after all weights are cleared
        load_config(1'b1);
        draw_vec(x0);
        run_problem(x0, 1'b1);

        @(posedge clk);
        if (results_seen != num_runs) begin
            stop_run($sformatf("only %0d of %0d results were taken", results_seen, num_runs));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== files.f ====
lbfgs_pkg.sv
objective_unit.sv
vector_unit.sv
line_search.sv
lbfgs_ctrl.sv
lbfgs_top.sv
tb_clock.sv
tb_lbfgs.sv

// ==== Makefile ====
# Verilator build and run of the L-BFGS style minimizer testbench

TOP             ?= tb_lbfgs
SIM_DIR         ?= obj_dir
FILE_LIST       ?= files.f
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP SIM_DIR FILE_LIST VERILATOR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILE_LIST)
	$(SIM_DIR)/V$(TOP)

clean:
	rm -rf $(SIM_DIR)
